// File: common/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 64;

  typedef logic [xlen-1:0] xlen_t;        // Register value, pc, immediate, address
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [3:0]      trap_cause_t;
  typedef logic [11:0]     csr_addr_t;

  // ALU operation codes
  localparam alu_op_t alu_nop  = 4'b0000;
  localparam alu_op_t alu_add  = 4'b0001;
  localparam alu_op_t alu_sub  = 4'b0010;
  localparam alu_op_t alu_and  = 4'b0011;
  localparam alu_op_t alu_or   = 4'b0100;
  localparam alu_op_t alu_xor  = 4'b0101;
  localparam alu_op_t alu_sll  = 4'b0110;
  localparam alu_op_t alu_srl  = 4'b0111;
  localparam alu_op_t alu_sra  = 4'b1000;
  localparam alu_op_t alu_slt  = 4'b1001;
  localparam alu_op_t alu_sltu = 4'b1010;

  // Trap causes, mcause encoding
  localparam trap_cause_t cause_illegal    = 4'd2;
  localparam trap_cause_t cause_breakpoint = 4'd3;
  localparam trap_cause_t cause_ecall      = 4'd8;   // U-mode ecall

  // Major opcodes
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam instr_t nop_instr = 32'h0000_0013;   // addi x0, x0, 0

endpackage

// File: design/regfile.sv
module regfile (
  input  logic             clk,
  input  logic             resetn,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  logic             we,
  input  rv_pkg::reg_idx_t wr_idx,
  input  rv_pkg::xlen_t    wr_data,
  output rv_pkg::xlen_t    rs1_data,
  output rv_pkg::xlen_t    rs2_data
);

  rv_pkg::xlen_t regs [1:31];   // x0 has no storage

  // Write-first read so a dependent instruction sees the value being retired
  function automatic rv_pkg::xlen_t read_port(input rv_pkg::reg_idx_t idx);
    rv_pkg::xlen_t val;
    if (idx == '0) val = '0;
    else if (we && wr_idx == idx) val = wr_data;
    else val = regs[idx];
    return val;
  endfunction

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rs1_data = read_port(rs1_idx);
  assign rs2_data = read_port(rs2_idx);

  // A bypassed read returns what the write leaves in storage
  a_bypass_stored: assert property (@(posedge clk) disable iff (!resetn)
    (we && rs1_idx != '0 && rs1_idx == wr_idx) |=> (regs[$past(rs1_idx)] == $past(rs1_data)));

endmodule

// File: decode/idecode.sv
module idecode (
  input  logic                clk,
  input  logic                resetn,
  input  logic                flush,
  input  logic                squash,
  input  logic                stall,
  input  rv_pkg::instr_t      instr,
  input  rv_pkg::xlen_t       pc,
  input  rv_pkg::xlen_t       rs1_data,
  input  rv_pkg::xlen_t       rs2_data,

  output logic [6:0]          opcode,
  output rv_pkg::reg_idx_t    rd,
  output rv_pkg::reg_idx_t    rs1,
  output rv_pkg::reg_idx_t    rs2,
  output logic [2:0]          funct3,
  output rv_pkg::xlen_t       imm,
  output rv_pkg::alu_op_t     alu_op,
  output rv_pkg::xlen_t       pc_q,
  output rv_pkg::xlen_t       op_a,
  output rv_pkg::xlen_t       op_b,
  output rv_pkg::trap_cause_t trap_cause,
  output rv_pkg::csr_addr_t   csr_addr,
  output logic                is_csr,
  output logic                csr_read,
  output logic                csr_write,
  output logic                trap,
  output logic                reg_write_enable,
  output logic                mem_read,
  output logic                mem_write,
  output logic                is_branch,
  output logic                jump
);

  logic                kill;
  rv_pkg::instr_t      d_instr;
  rv_pkg::xlen_t       imm_d;
  rv_pkg::alu_op_t     alu_op_d;
  rv_pkg::trap_cause_t trap_cause_d;
  rv_pkg::csr_addr_t   csr_addr_d;
  logic is_csr_d, csr_read_d, csr_write_d, trap_d;
  logic reg_write_enable_d, mem_read_d, mem_write_d, is_branch_d, jump_d;

  assign kill    = flush | squash;
  assign d_instr = kill ? rv_pkg::nop_instr : instr;   // Killed slot decodes as NOP

  always_comb begin
    imm_d              = '0;
    alu_op_d           = rv_pkg::alu_nop;
    trap_cause_d       = '0;
    csr_addr_d         = '0;
    is_csr_d           = 1'b0;
    csr_read_d         = 1'b0;
    csr_write_d        = 1'b0;
    trap_d             = 1'b0;
    reg_write_enable_d = 1'b0;
    mem_read_d         = 1'b0;
    mem_write_d        = 1'b0;
    is_branch_d        = 1'b0;
    jump_d             = 1'b0;

    case (d_instr[6:0])
      rv_pkg::op_reg: begin
        reg_write_enable_d = 1'b1;
        case ({d_instr[31:25], d_instr[14:12]})
          10'b0000000_000: alu_op_d = rv_pkg::alu_add;
          10'b0100000_000: alu_op_d = rv_pkg::alu_sub;
          10'b0000000_111: alu_op_d = rv_pkg::alu_and;
          10'b0000000_110: alu_op_d = rv_pkg::alu_or;
          10'b0000000_100: alu_op_d = rv_pkg::alu_xor;
          10'b0000000_001: alu_op_d = rv_pkg::alu_sll;
          10'b0000000_101: alu_op_d = rv_pkg::alu_srl;
          10'b0100000_101: alu_op_d = rv_pkg::alu_sra;
          10'b0000000_010: alu_op_d = rv_pkg::alu_slt;
          10'b0000000_011: alu_op_d = rv_pkg::alu_sltu;
          default:         alu_op_d = rv_pkg::alu_nop;
        endcase
      end
      rv_pkg::op_imm: begin
        reg_write_enable_d = 1'b1;
        imm_d = {{52{d_instr[31]}}, d_instr[31:20]};
        case (d_instr[14:12])
          3'b000:  alu_op_d = rv_pkg::alu_add;
          3'b111:  alu_op_d = rv_pkg::alu_and;
          3'b110:  alu_op_d = rv_pkg::alu_or;
          3'b100:  alu_op_d = rv_pkg::alu_xor;
          3'b010:  alu_op_d = rv_pkg::alu_slt;
          3'b011:  alu_op_d = rv_pkg::alu_sltu;
          3'b001:  alu_op_d = rv_pkg::alu_sll;
          default: alu_op_d = d_instr[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
        endcase
      end
      rv_pkg::op_load: begin
        reg_write_enable_d = 1'b1;
        mem_read_d         = 1'b1;
        alu_op_d           = rv_pkg::alu_add;
        imm_d = {{52{d_instr[31]}}, d_instr[31:20]};
      end
      rv_pkg::op_store: begin
        mem_write_d = 1'b1;
        alu_op_d    = rv_pkg::alu_add;
        imm_d = {{52{d_instr[31]}}, d_instr[31:25], d_instr[11:7]};
      end
      rv_pkg::op_branch: begin
        is_branch_d = 1'b1;
        imm_d = {{52{d_instr[31]}}, d_instr[7], d_instr[30:25], d_instr[11:8], 1'b0};
      end
      rv_pkg::op_jal: begin
        reg_write_enable_d = 1'b1;
        jump_d             = 1'b1;
        alu_op_d           = rv_pkg::alu_add;
        imm_d = {{44{d_instr[31]}}, d_instr[19:12], d_instr[20], d_instr[30:21], 1'b0};
      end
      rv_pkg::op_jalr: begin
        reg_write_enable_d = 1'b1;
        jump_d             = 1'b1;
        alu_op_d           = rv_pkg::alu_add;
        imm_d = {{52{d_instr[31]}}, d_instr[31:20]};
      end
      rv_pkg::op_lui: begin
        reg_write_enable_d = 1'b1;
        imm_d = {{32{d_instr[31]}}, d_instr[31:12], 12'b0};
      end
      rv_pkg::op_auipc: begin
        reg_write_enable_d = 1'b1;
        alu_op_d           = rv_pkg::alu_add;
        imm_d = {{32{d_instr[31]}}, d_instr[31:12], 12'b0};
      end
      rv_pkg::op_system: begin
        if (d_instr[14:12] == 3'b000) begin
          trap_d = 1'b1;
          case (d_instr[31:20])
            12'h000: trap_cause_d = rv_pkg::cause_ecall;
            12'h001: trap_cause_d = rv_pkg::cause_breakpoint;
            default: trap_cause_d = rv_pkg::cause_illegal;
          endcase
        end else begin
          is_csr_d           = 1'b1;
          csr_addr_d         = d_instr[31:20];
          reg_write_enable_d = (d_instr[11:7] != '0);
          // Swap forms read only for a real rd, set/clear forms write only for nonzero rs1/uimm
          if (d_instr[13:12] == 2'b01) begin
            csr_read_d  = (d_instr[11:7] != '0);
            csr_write_d = 1'b1;
          end else begin
            csr_read_d  = 1'b1;
            csr_write_d = (d_instr[19:15] != '0);
          end
          if (d_instr[14]) imm_d = {59'd0, d_instr[19:15]};   // Zero-extended uimm
          if (d_instr[14:12] == 3'b100) begin
            trap_d       = 1'b1;
            trap_cause_d = rv_pkg::cause_illegal;
          end
        end
      end
      default: begin
        trap_d       = 1'b1;
        trap_cause_d = rv_pkg::cause_illegal;
      end
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      opcode           <= rv_pkg::op_imm;   // Decoded NOP
      rd               <= '0;
      rs1              <= '0;
      rs2              <= '0;
      funct3           <= '0;
      alu_op           <= rv_pkg::alu_add;
      trap_cause       <= '0;
      is_csr           <= 1'b0;
      csr_read         <= 1'b0;
      csr_write        <= 1'b0;
      trap             <= 1'b0;
      reg_write_enable <= 1'b1;
      mem_read         <= 1'b0;
      mem_write        <= 1'b0;
      is_branch        <= 1'b0;
      jump             <= 1'b0;
    end else if (flush || !stall) begin
      opcode           <= d_instr[6:0];
      rd               <= d_instr[11:7];
      rs1              <= d_instr[19:15];
      rs2              <= d_instr[24:20];
      funct3           <= d_instr[14:12];
      alu_op           <= alu_op_d;
      trap_cause       <= trap_cause_d;
      is_csr           <= is_csr_d;
      csr_read         <= csr_read_d;
      csr_write        <= csr_write_d;
      trap             <= trap_d;
      reg_write_enable <= reg_write_enable_d;
      mem_read         <= mem_read_d;
      mem_write        <= mem_write_d;
      is_branch        <= is_branch_d;
      jump             <= jump_d;
    end
  end

  always_ff @(posedge clk) begin
    if (flush || !stall) begin
      imm      <= imm_d;
      pc_q     <= pc;
      op_a     <= kill ? '0 : rs1_data;
      op_b     <= kill ? '0 : rs2_data;
      csr_addr <= csr_addr_d;
    end
  end

  // A killed slot enters decode as an inert NOP
  a_kill_inert: assert property (@(posedge clk) disable iff (!resetn)
    (kill && (flush || !stall)) |=> (rd == '0 && !trap && !mem_read && !mem_write &&
                                     !is_branch && !jump && !is_csr));

endmodule

// File: design/execute_stage.sv
module execute_stage (
  input  logic                clk,
  input  logic                resetn,
  input  logic                stall,
  input  logic [6:0]          opcode,
  input  rv_pkg::reg_idx_t    rd,
  input  rv_pkg::reg_idx_t    rs1,
  input  rv_pkg::reg_idx_t    rs2,
  input  logic [2:0]          funct3,
  input  rv_pkg::xlen_t       imm,
  input  rv_pkg::alu_op_t     alu_op,
  input  rv_pkg::xlen_t       pc,
  input  rv_pkg::xlen_t       op_a,
  input  rv_pkg::xlen_t       op_b,
  input  logic                reg_write_enable,
  input  logic                mem_read,
  input  logic                mem_write,
  input  logic                is_branch,
  input  logic                jump,
  input  logic                trap,
  input  rv_pkg::trap_cause_t trap_cause,
  input  logic                is_csr,
  input  logic                csr_read,
  input  logic                csr_write,
  input  rv_pkg::csr_addr_t   csr_addr,
  output logic                squash,
  output logic                wb_en,
  output rv_pkg::reg_idx_t    wb_rd,
  output rv_pkg::xlen_t       wb_data,
  output logic                mem_read_q,
  output logic                mem_write_q,
  output rv_pkg::xlen_t       mem_addr,
  output rv_pkg::xlen_t       store_data,
  output logic                redirect,
  output rv_pkg::xlen_t       redirect_pc,
  output logic                trap_q,
  output rv_pkg::trap_cause_t trap_cause_q,
  output logic                csr_req,
  output rv_pkg::csr_addr_t   csr_addr_q,
  output logic                csr_write_q
);

  rv_pkg::xlen_t fwd_a, fwd_b, alu_b, alu_res, result, pc_imm, target;
  logic [5:0]    shamt;
  logic          cond;

  // Bypass from the instruction retiring this cycle
  assign fwd_a  = (wb_en && wb_rd == rs1) ? wb_data : op_a;
  assign fwd_b  = (wb_en && wb_rd == rs2) ? wb_data : op_b;
  assign alu_b  = (opcode == rv_pkg::op_reg) ? fwd_b : imm;
  assign shamt  = alu_b[5:0];
  assign pc_imm = pc + imm;

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  alu_res = fwd_a + alu_b;
      rv_pkg::alu_sub:  alu_res = fwd_a - alu_b;
      rv_pkg::alu_and:  alu_res = fwd_a & alu_b;
      rv_pkg::alu_or:   alu_res = fwd_a | alu_b;
      rv_pkg::alu_xor:  alu_res = fwd_a ^ alu_b;
      rv_pkg::alu_sll:  alu_res = fwd_a << shamt;
      rv_pkg::alu_srl:  alu_res = fwd_a >> shamt;
      rv_pkg::alu_sra:  alu_res = $signed(fwd_a) >>> shamt;
      rv_pkg::alu_slt:  alu_res = {63'd0, $signed(fwd_a) < $signed(alu_b)};
      rv_pkg::alu_sltu: alu_res = {63'd0, fwd_a < alu_b};
      default:          alu_res = '0;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  cond = (fwd_a == fwd_b);
      3'b001:  cond = (fwd_a != fwd_b);
      3'b100:  cond = ($signed(fwd_a) < $signed(fwd_b));
      3'b101:  cond = ($signed(fwd_a) >= $signed(fwd_b));
      3'b110:  cond = (fwd_a < fwd_b);
      3'b111:  cond = (fwd_a >= fwd_b);
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      rv_pkg::op_lui:   result = imm;
      rv_pkg::op_auipc: result = pc_imm;
      rv_pkg::op_jal,
      rv_pkg::op_jalr:  result = pc + 64'd4;   // Link value
      default:          result = alu_res;
    endcase
  end

  assign target = (opcode == rv_pkg::op_jalr) ? ((fwd_a + imm) & ~64'd1) : pc_imm;
  assign squash = (is_branch && cond) || jump;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wb_en       <= 1'b0;
      mem_read_q  <= 1'b0;
      mem_write_q <= 1'b0;
      redirect    <= 1'b0;
      trap_q      <= 1'b0;
      csr_req     <= 1'b0;
      csr_write_q <= 1'b0;
    end else if (!stall) begin
      // CSR results come from the CSR file outside, so no register write here
      wb_en       <= reg_write_enable && !mem_read && !trap && !is_csr && rd != '0;
      mem_read_q  <= mem_read;
      mem_write_q <= mem_write;
      redirect    <= squash;
      trap_q      <= trap;
      csr_req     <= is_csr && !trap && (csr_read || csr_write);
      csr_write_q <= csr_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      wb_rd        <= rd;
      wb_data      <= result;
      mem_addr     <= fwd_a + imm;
      store_data   <= fwd_b;
      redirect_pc  <= target;
      trap_cause_q <= trap_cause;
      csr_addr_q   <= csr_addr;
    end
  end

  // A redirect kills the next slot and never repeats
  a_one_redirect: assert property (@(posedge clk) disable iff (!resetn)
    (redirect && !stall) |=> !redirect);

endmodule

// File: design/core_pipe.sv
module core_pipe (
  input  logic                clk,
  input  logic                resetn,
  input  rv_pkg::instr_t      instr,
  input  rv_pkg::xlen_t       pc,
  input  logic                stall,
  input  logic                flush,
  output logic                wb_en,
  output rv_pkg::reg_idx_t    wb_rd,
  output rv_pkg::xlen_t       wb_data,
  output logic                mem_read,
  output logic                mem_write,
  output rv_pkg::xlen_t       mem_addr,
  output rv_pkg::xlen_t       store_data,
  output logic                redirect,
  output rv_pkg::xlen_t       redirect_pc,
  output logic                trap,
  output rv_pkg::trap_cause_t trap_cause,
  output logic                csr_req,
  output rv_pkg::csr_addr_t   csr_addr,
  output logic                csr_write
);

  rv_pkg::xlen_t       rs1_data, rs2_data;
  logic                squash;
  logic [6:0]          d_opcode;
  rv_pkg::reg_idx_t    d_rd, d_rs1, d_rs2;
  logic [2:0]          d_funct3;
  rv_pkg::xlen_t       d_imm, d_pc, d_op_a, d_op_b;
  rv_pkg::alu_op_t     d_alu_op;
  rv_pkg::trap_cause_t d_trap_cause;
  rv_pkg::csr_addr_t   d_csr_addr;
  logic d_is_csr, d_csr_read, d_csr_write, d_trap, d_reg_write_enable;
  logic d_mem_read, d_mem_write, d_is_branch, d_jump;

  // Held wb outputs rewrite the same value while stalled
  regfile i_regfile (
    .clk      (clk),
    .resetn   (resetn),
    .rs1_idx  (instr[19:15]),
    .rs2_idx  (instr[24:20]),
    .we       (wb_en),
    .wr_idx   (wb_rd),
    .wr_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  idecode i_idecode (
    .clk(clk), .resetn(resetn), .flush(flush), .squash(squash), .stall(stall),
    .instr(instr), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .opcode(d_opcode), .rd(d_rd), .rs1(d_rs1), .rs2(d_rs2), .funct3(d_funct3),
    .imm(d_imm), .alu_op(d_alu_op), .pc_q(d_pc), .op_a(d_op_a), .op_b(d_op_b),
    .trap_cause(d_trap_cause), .csr_addr(d_csr_addr), .is_csr(d_is_csr),
    .csr_read(d_csr_read), .csr_write(d_csr_write), .trap(d_trap),
    .reg_write_enable(d_reg_write_enable), .mem_read(d_mem_read),
    .mem_write(d_mem_write), .is_branch(d_is_branch), .jump(d_jump)
  );

  execute_stage i_execute_stage (
    .clk(clk), .resetn(resetn), .stall(stall),
    .opcode(d_opcode), .rd(d_rd), .rs1(d_rs1), .rs2(d_rs2), .funct3(d_funct3),
    .imm(d_imm), .alu_op(d_alu_op), .pc(d_pc), .op_a(d_op_a), .op_b(d_op_b),
    .reg_write_enable(d_reg_write_enable), .mem_read(d_mem_read),
    .mem_write(d_mem_write), .is_branch(d_is_branch), .jump(d_jump),
    .trap(d_trap), .trap_cause(d_trap_cause), .is_csr(d_is_csr),
    .csr_read(d_csr_read), .csr_write(d_csr_write), .csr_addr(d_csr_addr),
    .squash(squash), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .mem_read_q(mem_read), .mem_write_q(mem_write), .mem_addr(mem_addr),
    .store_data(store_data), .redirect(redirect), .redirect_pc(redirect_pc),
    .trap_q(trap), .trap_cause_q(trap_cause), .csr_req(csr_req),
    .csr_addr_q(csr_addr), .csr_write_q(csr_write)
  );

endmodule

// File: test/tb_core_pipe.sv
module tb_core_pipe;

  localparam int n_alu = 200;
  localparam int n_jump = 8;
  localparam int n_ms = 12;
  localparam int n_stall = 150;
  // Slots per test, stall slack and drains, plus margin
  localparam int cycle_limit = 4 + n_alu + n_jump * 6 + 6 * 11 + n_ms * 9 + n_stall * 3 + 6 * 3 + 50;

  typedef struct packed {
    logic                wb_en;
    rv_pkg::reg_idx_t    wb_rd;
    rv_pkg::xlen_t       wb_data;
    logic                mem_read;
    logic                mem_write;
    rv_pkg::xlen_t       mem_addr;
    rv_pkg::xlen_t       store_data;
    logic                redirect;
    rv_pkg::xlen_t       redirect_pc;
    logic                trap;
    rv_pkg::trap_cause_t trap_cause;
    logic                csr_req;
    rv_pkg::csr_addr_t   csr_addr;
    logic                csr_write;
  } exp_t;

  logic clk = 1'b0;
  logic resetn;
  rv_pkg::instr_t instr;
  rv_pkg::xlen_t pc;
  logic stall, flush;
  logic wb_en, mem_read, mem_write, redirect, trap, csr_req, csr_write;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::xlen_t wb_data, mem_addr, store_data, redirect_pc;
  rv_pkg::trap_cause_t trap_cause;
  rv_pkg::csr_addr_t csr_addr;

  rv_pkg::xlen_t model_regs [0:31];
  exp_t exp_q [$];
  rv_pkg::xlen_t cur_pc;
  logic kill_next;
  logic stall_mode;
  int errors, checks, cycles, n_tests;

  core_pipe i_core_pipe (
    .clk(clk), .resetn(resetn), .instr(instr), .pc(pc), .stall(stall), .flush(flush),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .mem_read(mem_read),
    .mem_write(mem_write), .mem_addr(mem_addr), .store_data(store_data),
    .redirect(redirect), .redirect_pc(redirect_pc), .trap(trap),
    .trap_cause(trap_cause), .csr_req(csr_req), .csr_addr(csr_addr), .csr_write(csr_write)
  );

  always #2 clk = ~clk;

  function automatic rv_pkg::instr_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t r2,
                                           input rv_pkg::reg_idx_t r1, input logic [2:0] f3,
                                           input rv_pkg::reg_idx_t rd);
    return {f7, r2, r1, f3, rd, rv_pkg::op_reg};
  endfunction

  function automatic rv_pkg::instr_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t r1,
                                           input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                           input logic [6:0] op);
    return {imm, r1, f3, rd, op};
  endfunction

  function automatic rv_pkg::instr_t enc_s(input logic [11:0] imm, input rv_pkg::reg_idx_t r2,
                                           input rv_pkg::reg_idx_t r1);
    return {imm[11:5], r2, r1, 3'b011, imm[4:0], rv_pkg::op_store};
  endfunction

  function automatic rv_pkg::instr_t enc_b(input logic [12:0] imm, input rv_pkg::reg_idx_t r2,
                                           input rv_pkg::reg_idx_t r1, input logic [2:0] f3);
    return {imm[12], imm[10:5], r2, r1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
  endfunction

  function automatic rv_pkg::instr_t enc_j(input logic [20:0] imm, input rv_pkg::reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
  endfunction

  function automatic rv_pkg::instr_t random_alu();
    rv_pkg::reg_idx_t rd, r1, r2;
    logic [11:0] imm;
    logic [2:0] f3;
    int sel;
    sel = int'($urandom % 8);
    rd = 5'($urandom % 8);   // Small register range gives dense dependencies
    r1 = 5'($urandom % 8);
    r2 = 5'($urandom % 8);
    imm = 12'($urandom);
    f3 = 3'($urandom);
    if (sel < 3) begin
      case ($urandom % 10)
        0: return enc_r(7'h00, r2, r1, 3'b000, rd);
        1: return enc_r(7'h20, r2, r1, 3'b000, rd);   // sub
        2: return enc_r(7'h00, r2, r1, 3'b111, rd);
        3: return enc_r(7'h00, r2, r1, 3'b110, rd);
        4: return enc_r(7'h00, r2, r1, 3'b100, rd);
        5: return enc_r(7'h00, r2, r1, 3'b001, rd);
        6: return enc_r(7'h00, r2, r1, 3'b101, rd);
        7: return enc_r(7'h20, r2, r1, 3'b101, rd);   // sra
        8: return enc_r(7'h00, r2, r1, 3'b010, rd);
        default: return enc_r(7'h00, r2, r1, 3'b011, rd);
      endcase
    end else if (sel < 6) begin
      if (f3 == 3'b001) imm = {6'd0, imm[5:0]};
      if (f3 == 3'b101) imm = {1'b0, imm[10], 4'd0, imm[5:0]};   // srli or srai
      return enc_i(imm, r1, f3, rd, rv_pkg::op_imm);
    end else if (sel == 6) begin
      return {20'($urandom), rd, rv_pkg::op_lui};
    end
    return {20'($urandom), rd, rv_pkg::op_auipc};
  endfunction

  // Expected outputs of one instruction, updating the model registers in order
  function automatic exp_t model_exec(input rv_pkg::instr_t ins, input rv_pkg::xlen_t ipc);
    exp_t e;
    logic [6:0] opc;
    logic [2:0] f3;
    rv_pkg::reg_idx_t rd, r1;
    rv_pkg::xlen_t a, b, immi, imms, immb, immu, immj, res;
    logic writes, taken;
    e = '0;
    opc = ins[6:0];
    f3 = ins[14:12];
    rd = ins[11:7];
    r1 = ins[19:15];
    a = model_regs[r1];
    b = model_regs[ins[24:20]];
    immi = {{52{ins[31]}}, ins[31:20]};
    imms = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    immb = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immu = {{32{ins[31]}}, ins[31:12], 12'd0};
    immj = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    res = '0;
    writes = 1'b0;
    taken = 1'b0;
    case (opc)
      rv_pkg::op_reg, rv_pkg::op_imm: begin
        writes = 1'b1;
        if (opc == rv_pkg::op_imm) b = immi;
        case (f3)
          3'b000: res = (opc == rv_pkg::op_reg && ins[30]) ? a - b : a + b;
          3'b111: res = a & b;
          3'b110: res = a | b;
          3'b100: res = a ^ b;
          3'b001: res = a << b[5:0];
          3'b101: res = ins[30] ? rv_pkg::xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
          3'b010: res = {63'd0, $signed(a) < $signed(b)};
          default: res = {63'd0, a < b};
        endcase
      end
      rv_pkg::op_lui: begin
        writes = 1'b1;
        res = immu;
      end
      rv_pkg::op_auipc: begin
        writes = 1'b1;
        res = ipc + immu;
      end
      rv_pkg::op_jal, rv_pkg::op_jalr: begin
        writes = 1'b1;
        res = ipc + 64'd4;
        e.redirect = 1'b1;
        e.redirect_pc = (opc == rv_pkg::op_jal) ? ipc + immj : (a + immi) & ~64'd1;
      end
      rv_pkg::op_branch: begin
        case (f3)
          3'b000: taken = (a == b);
          3'b001: taken = (a != b);
          3'b100: taken = ($signed(a) < $signed(b));
          3'b101: taken = ($signed(a) >= $signed(b));
          3'b110: taken = (a < b);
          3'b111: taken = (a >= b);
          default: taken = 1'b0;
        endcase
        e.redirect = taken;
        e.redirect_pc = ipc + immb;
      end
      rv_pkg::op_load: begin
        e.mem_read = 1'b1;
        e.mem_addr = a + immi;
      end
      rv_pkg::op_store: begin
        e.mem_write = 1'b1;
        e.mem_addr = a + imms;
        e.store_data = b;
      end
      rv_pkg::op_system: begin
        if (f3 == 3'b000) begin
          e.trap = 1'b1;
          if (ins[31:20] == 12'h000) e.trap_cause = rv_pkg::cause_ecall;
          else if (ins[31:20] == 12'h001) e.trap_cause = rv_pkg::cause_breakpoint;
          else e.trap_cause = rv_pkg::cause_illegal;
        end else if (f3 == 3'b100) begin
          e.trap = 1'b1;
          e.trap_cause = rv_pkg::cause_illegal;
        end else begin
          e.csr_req = 1'b1;
          e.csr_addr = ins[31:20];
          e.csr_write = (f3[1:0] == 2'b01) ? 1'b1 : (r1 != 5'd0);   // x0 source writes nothing
        end
      end
      default: begin
        e.trap = 1'b1;
        e.trap_cause = rv_pkg::cause_illegal;
      end
    endcase
    if (writes && rd != 5'd0) begin
      e.wb_en = 1'b1;
      e.wb_rd = rd;
      e.wb_data = res;
      model_regs[rd] = res;
    end
    return e;
  endfunction

  task automatic check_field(input string name, input rv_pkg::xlen_t got, input rv_pkg::xlen_t exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_outputs(input exp_t e);
    check_field("wb_en", 64'(wb_en), 64'(e.wb_en));
    if (e.wb_en) begin
      check_field("wb_rd", 64'(wb_rd), 64'(e.wb_rd));
      check_field("wb_data", wb_data, e.wb_data);
    end
    check_field("mem_read", 64'(mem_read), 64'(e.mem_read));
    check_field("mem_write", 64'(mem_write), 64'(e.mem_write));
    if (e.mem_read || e.mem_write) check_field("mem_addr", mem_addr, e.mem_addr);
    if (e.mem_write) check_field("store_data", store_data, e.store_data);
    check_field("redirect", 64'(redirect), 64'(e.redirect));
    if (e.redirect) check_field("redirect_pc", redirect_pc, e.redirect_pc);
    check_field("trap", 64'(trap), 64'(e.trap));
    if (e.trap) check_field("trap_cause", 64'(trap_cause), 64'(e.trap_cause));
    check_field("csr_req", 64'(csr_req), 64'(e.csr_req));
    if (e.csr_req) begin
      check_field("csr_addr", 64'(csr_addr), 64'(e.csr_addr));
      check_field("csr_write", 64'(csr_write), 64'(e.csr_write));
    end
  endtask

  // Called on a falling edge, returns on the next one after the slot is taken
  task automatic drive_slot(input rv_pkg::instr_t ins);
    exp_t e;
    logic fl;
    while (stall_mode && ($urandom % 4 == 0)) begin
      stall = 1'b1;
      flush = 1'b0;
      instr = $urandom;   // Ignored while stalled
      @(negedge clk);
    end
    fl = stall_mode && ($urandom % 8 == 0);
    stall = 1'b0;
    flush = fl;
    instr = ins;
    pc = cur_pc;
    if (fl || kill_next) e = '0;   // Flushed or squashed slot retires nothing
    else e = model_exec(ins, cur_pc);
    kill_next = e.redirect;
    exp_q.push_back(e);
    cur_pc = cur_pc + 64'd4;
    @(negedge clk);
  endtask

  task automatic end_test(input string name, input int err_start);
    stall_mode = 1'b0;
    repeat (3) drive_slot(rv_pkg::nop_instr);
    n_tests++;
    $display("test %s done, %0d mismatches", name, errors - err_start);
  endtask

  // Slot k-1 reaches the outputs at the edge that captures slot k
  always @(posedge clk) begin
    if (resetn && !stall && exp_q.size() >= 2) begin
      #1;
      check_outputs(exp_q.pop_front());
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    int err_start;
    logic [2:0] br_f3 [6];
    rv_pkg::reg_idx_t rr;
    br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    err_start = int'($urandom(32'h1cc));
    resetn = 1'b0;
    instr = rv_pkg::nop_instr;
    pc = '0;
    stall = 1'b0;
    flush = 1'b0;
    cur_pc = 64'h1000;
    kill_next = 1'b0;
    stall_mode = 1'b0;
    errors = 0;
    checks = 0;
    cycles = 0;
    n_tests = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;

    err_start = errors;
    check_field("wb_en", 64'(wb_en), 64'd0);
    check_field("mem_read", 64'(mem_read), 64'd0);
    check_field("mem_write", 64'(mem_write), 64'd0);
    check_field("redirect", 64'(redirect), 64'd0);
    check_field("trap", 64'(trap), 64'd0);
    check_field("csr_req", 64'(csr_req), 64'd0);
    n_tests++;
    $display("test reset_state done, %0d mismatches", errors - err_start);

    err_start = errors;
    repeat (n_alu) drive_slot(random_alu());
    end_test("alu_random", err_start);

    err_start = errors;
    repeat (n_jump) begin
      drive_slot({20'($urandom), 5'($urandom % 8), rv_pkg::op_lui});
      drive_slot({20'($urandom), 5'($urandom % 8), rv_pkg::op_auipc});
      drive_slot(enc_j({20'($urandom), 1'b0}, 5'($urandom % 8)));
      drive_slot(random_alu());   // Squashed
      drive_slot(enc_i(12'($urandom), 5'($urandom % 8), 3'b000, 5'($urandom % 8),
                       rv_pkg::op_jalr));
      drive_slot(random_alu());   // Squashed
    end
    end_test("upper_and_jumps", err_start);

    err_start = errors;
    foreach (br_f3[i]) begin
      for (int r = 1; r <= 2; r++) begin
        rr = 5'(r);
        drive_slot({20'($urandom), rr, rv_pkg::op_lui});
        drive_slot(enc_i(12'($urandom), rr, 3'b000, rr, rv_pkg::op_imm));
      end
      drive_slot(enc_i(12'd0, 5'd1, 3'b000, 5'd3, rv_pkg::op_imm));   // x3 = x1
      drive_slot(enc_b({12'($urandom), 1'b0}, 5'd2, 5'd1, br_f3[i]));
      drive_slot(enc_i(12'd1, 5'd5, 3'b000, 5'd5, rv_pkg::op_imm));
      drive_slot(enc_b({12'($urandom), 1'b0}, 5'd1, 5'd2, br_f3[i]));
      drive_slot(enc_i(12'd1, 5'd5, 3'b000, 5'd5, rv_pkg::op_imm));
      drive_slot(enc_b({12'($urandom), 1'b0}, 5'd3, 5'd1, br_f3[i]));
      drive_slot(enc_i(12'd1, 5'd5, 3'b000, 5'd5, rv_pkg::op_imm));
    end
    end_test("branches", err_start);

    err_start = errors;
    repeat (n_ms) begin
      drive_slot(random_alu());
      drive_slot(enc_i(12'($urandom), 5'($urandom % 8), 3'b011, 5'($urandom % 8),
                       rv_pkg::op_load));
      drive_slot(enc_s(12'($urandom), 5'($urandom % 8), 5'($urandom % 8)));
      drive_slot(32'h0000_0073);   // ecall
      drive_slot(32'h0010_0073);   // ebreak
      drive_slot({25'($urandom), 7'b1111111});
      drive_slot({12'($urandom), 5'($urandom % 4), 3'($urandom % 3 + 1), 5'($urandom % 4),
                  rv_pkg::op_system});
      drive_slot({12'($urandom), 5'($urandom % 4), 3'($urandom % 3 + 5), 5'($urandom % 4),
                  rv_pkg::op_system});
      drive_slot({12'($urandom), 5'($urandom % 4), 3'b100, 5'($urandom % 4), rv_pkg::op_system});
    end
    end_test("mem_and_system", err_start);

    err_start = errors;
    stall_mode = 1'b1;
    repeat (n_stall) drive_slot(random_alu());
    end_test("stall_flush", err_start);

    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
common/rv_pkg.sv
design/regfile.sv
decode/idecode.sv
design/execute_stage.sv
design/core_pipe.sv
test/tb_core_pipe.sv

// File: run.sh
#!/bin/sh
# Build and run the core_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core_pipe \
  -f sources.f -o sim_core_pipe
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_core_pipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0
